// ==== Bender.yml ====
package:
  name: virtual_fabric

sources:
  - fabric_pkg.sv
  - config_port.sv
  - dsp_slice.sv
  - pe.sv
  - virtual_fabric.sv
  - target: simulation
    files:
      - tb_virtual_fabric.sv

// ==== config_port.sv ====
`timescale 1ns/1ps

module config_port
  import fabric_pkg::*;
#(
  parameter int NUM_PE = 3
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cfg_req,
  input  cfg_write_t             cfg_wr,
  output logic                   cfg_ack,
  output pe_cfg_t [NUM_PE-1:0]   cfg_array
);

  typedef enum logic {
    CFG_IDLE,
    CFG_ACK
  } cfg_state_e;

  cfg_state_e state;

  // merge one write into an element's current configuration
  function automatic pe_cfg_t apply_write(pe_cfg_t cur, cfg_write_t wr);
    pe_cfg_t nxt;
    nxt = cur;
    case (wr.field)
      FIELD_CTRL:
      begin
        nxt.op    = pe_op_e'(wr.data[2:0]);
        nxt.src_d = route_src_e'(wr.data[4:3]);
        nxt.src_p = route_src_e'(wr.data[6:5]);
        nxt.src_b = route_src_e'(wr.data[8:7]);
      end
      FIELD_D_IM: nxt.d_im = wr.data;
      FIELD_P_IM: nxt.p_im = wr.data;
      FIELD_B_IM: nxt.b_im = wr.data;
      default:    nxt = cur;
    endcase
    return nxt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // four-phase slave

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= CFG_IDLE;
      for (int i = 0; i < NUM_PE; i++)
        cfg_array[i] <= PE_CFG_DEFAULT;
    end
    else
    begin
      case (state)
        CFG_IDLE:
          if (cfg_req)
          begin
            state <= CFG_ACK;
            // an index past the chain matches nothing but is still acked
            for (int i = 0; i < NUM_PE; i++)
              if (cfg_wr.pe_idx == i)
                cfg_array[i] <= apply_write(cfg_array[i], cfg_wr);
          end
        CFG_ACK:
          if (!cfg_req)
            state <= CFG_IDLE;
        default: state <= CFG_IDLE;
      endcase
    end
  end

  assign cfg_ack = (state == CFG_ACK);

  // host keeps req up until it has seen ack
  assert property (@(posedge clk) disable iff (rst)
    cfg_req && !cfg_ack |=> cfg_req);

  assert property (@(posedge clk) disable iff (rst)
    cfg_req ##1 cfg_req |-> $stable(cfg_wr));

endmodule

// ==== dsp_slice.sv ====
`timescale 1ns/1ps

module dsp_slice
  import fabric_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              en,
  input  pe_op_e            op,
  input  logic [WORD_W-1:0] d,
  input  logic [WORD_W-1:0] p,
  input  logic [WORD_W-1:0] b,
  output logic [WORD_W-1:0] result
);

  pe_op_e            op_q;  // travels with its operands
  logic [WORD_W-1:0] d_q;
  logic [WORD_W-1:0] p_q;
  logic [WORD_W-1:0] b_q;
  logic [WORD_W-1:0] res;

  // stage 1: operand registers
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      op_q <= OP_PASS;
      d_q  <= '0;
      p_q  <= '0;
      b_q  <= '0;
    end
    else if (en)
    begin
      op_q <= op;
      d_q  <= d;
      p_q  <= p;
      b_q  <= b;
    end
  end

  // all results wrap to the lane width
  always_comb
  begin
    case (op_q)
      OP_PASS: res = p_q;
      OP_MUL:  res = d_q * b_q;
      OP_MAC:  res = d_q * b_q + p_q;
      OP_MSUB: res = p_q - d_q * b_q;
      OP_ADD:  res = d_q + p_q;
      default: res = '0;
    endcase
  end

  // stage 2: result register
  always_ff @(posedge clk)
  begin
    if (rst)
      result <= '0;
    else if (en)
      result <= res;
  end

  assert property (@(posedge clk) disable iff (rst)
    op_q inside {OP_PASS, OP_MUL, OP_MAC, OP_MSUB, OP_ADD});

endmodule

// ==== fabric_pkg.sv ====
package fabric_pkg;

  localparam int WORD_W   = 16;
  localparam int PE_IDX_W = 4;  // up to 16 elements

  // one word per lane, d on top
  typedef struct packed {
    logic [WORD_W-1:0] d;
    logic [WORD_W-1:0] p;
    logic [WORD_W-1:0] b;
  } lane_bundle_t;

  typedef enum logic [2:0] {
    OP_PASS = 3'd0,  // p
    OP_MUL  = 3'd1,  // d * b
    OP_MAC  = 3'd2,  // d * b + p
    OP_MSUB = 3'd3,  // p - d * b
    OP_ADD  = 3'd4   // d + p
  } pe_op_e;

  typedef enum logic [1:0] {
    SRC_UP_D = 2'd0,
    SRC_UP_P = 2'd1,
    SRC_UP_B = 2'd2,
    SRC_IMM  = 2'd3
  } route_src_e;

  typedef struct packed {
    pe_op_e            op;
    route_src_e        src_d;
    route_src_e        src_p;
    route_src_e        src_b;
    logic [WORD_W-1:0] d_im;
    logic [WORD_W-1:0] p_im;
    logic [WORD_W-1:0] b_im;
  } pe_cfg_t;

  typedef enum logic [1:0] {
    FIELD_CTRL = 2'd0,  // op [2:0], src_d [4:3], src_p [6:5], src_b [8:7]
    FIELD_D_IM = 2'd1,
    FIELD_P_IM = 2'd2,
    FIELD_B_IM = 2'd3
  } cfg_field_e;

  typedef struct packed {
    logic [PE_IDX_W-1:0] pe_idx;
    cfg_field_e          field;
    logic [WORD_W-1:0]   data;
  } cfg_write_t;

  // straight pass-through of the upstream bundle
  localparam pe_cfg_t PE_CFG_DEFAULT = '{
    op: OP_PASS, src_d: SRC_UP_D, src_p: SRC_UP_P, src_b: SRC_UP_B,
    d_im: '0, p_im: '0, b_im: '0
  };

endpackage

// ==== pe.sv ====
`timescale 1ns/1ps

module pe
  import fabric_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         en,
  input  pe_cfg_t      cfg,
  input  lane_bundle_t up,
  output lane_bundle_t out
);

  logic [WORD_W-1:0] d_sel;
  logic [WORD_W-1:0] p_sel;
  logic [WORD_W-1:0] b_sel;
  logic [WORD_W-1:0] d_q1;
  logic [WORD_W-1:0] d_q2;
  logic [WORD_W-1:0] b_q1;
  logic [WORD_W-1:0] b_q2;
  logic [WORD_W-1:0] slice_res;

  // operand routing from the upstream lanes or the immediates
  function automatic logic [WORD_W-1:0] pick(route_src_e src, lane_bundle_t lanes,
                                             logic [WORD_W-1:0] imm);
    case (src)
      SRC_UP_D: return lanes.d;
      SRC_UP_P: return lanes.p;
      SRC_UP_B: return lanes.b;
      default:  return imm;
    endcase
  endfunction

  assign d_sel = pick(cfg.src_d, up, cfg.d_im);
  assign p_sel = pick(cfg.src_p, up, cfg.p_im);
  assign b_sel = pick(cfg.src_b, up, cfg.b_im);

  dsp_slice u_dsp (
    .clk    (clk),
    .rst    (rst),
    .en     (en),
    .op     (cfg.op),
    .d      (d_sel),
    .p      (p_sel),
    .b      (b_sel),
    .result (slice_res)
  );

  ////////////////////////////////////////////////////////////////////////////
  // d and b follow the slice's two stages

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      d_q1 <= '0;
      d_q2 <= '0;
      b_q1 <= '0;
      b_q2 <= '0;
    end
    else if (en)
    begin
      d_q1 <= d_sel;
      d_q2 <= d_q1;
      b_q1 <= b_sel;
      b_q2 <= b_q1;
    end
  end

  assign out = '{d: d_q2, p: slice_res, b: b_q2};

endmodule

// ==== project.f ====
fabric_pkg.sv
config_port.sv
dsp_slice.sv
pe.sv
virtual_fabric.sv
tb_virtual_fabric.sv

// ==== tb_virtual_fabric.sv ====
`timescale 1ns/1ps

module tb_virtual_fabric
  import fabric_pkg::*;
();

  localparam int NUM_PE     = 3;
  localparam int DEPTH      = 2 * NUM_PE;  // en cycles from data_in to data_out
  localparam int MAX_CYCLES = 4000;        // all phases together need about 1100

  logic                clk;
  logic                rst;
  logic                en;
  logic [2*WORD_W-1:0] data_in;
  logic [2*WORD_W-1:0] data_out;
  logic                cfg_req;
  cfg_write_t          cfg_wr;
  logic                cfg_ack;

  integer              seed = 43;
  int                  errors = 0;
  int                  checks = 0;
  int                  cycles = 0;
  pe_cfg_t             shadow [NUM_PE];
  logic [2*WORD_W-1:0] hist [$];  // data_in of every en edge with the oldest first
  logic                pending_en = 1'b0;
  logic                pending_hold = 1'b0;
  logic [2*WORD_W-1:0] pending_in = '0;
  logic [2*WORD_W-1:0] last_out = '0;
  logic [2*WORD_W-1:0] exp_out;

  virtual_fabric #(
    .NUM_PE (NUM_PE)
  ) DUT (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .data_in  (data_in),
    .data_out (data_out),
    .cfg_req  (cfg_req),
    .cfg_wr   (cfg_wr),
    .cfg_ack  (cfg_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model

  function automatic logic [WORD_W-1:0] select_operand(route_src_e src, lane_bundle_t lanes,
                                                       logic [WORD_W-1:0] imm);
    if (src == SRC_IMM)
      return imm;
    else if (src == SRC_UP_D)
      return lanes.d;
    else if (src == SRC_UP_P)
      return lanes.p;
    return lanes.b;
  endfunction

  function automatic logic [2*WORD_W-1:0] expected_out(logic [2*WORD_W-1:0] din);
    lane_bundle_t        lanes;
    logic [WORD_W-1:0]   opd;
    logic [WORD_W-1:0]   opp;
    logic [WORD_W-1:0]   opb;
    logic [2*WORD_W-1:0] prod;  // full product before the wrap
    logic [WORD_W-1:0]   res;
    lanes.d = '0;
    lanes.p = din[2*WORD_W-1:WORD_W];
    lanes.b = din[WORD_W-1:0];
    for (int e = 0; e < NUM_PE; e++)
    begin
      opd  = select_operand(shadow[e].src_d, lanes, shadow[e].d_im);
      opp  = select_operand(shadow[e].src_p, lanes, shadow[e].p_im);
      opb  = select_operand(shadow[e].src_b, lanes, shadow[e].b_im);
      prod = opd * opb;
      case (shadow[e].op)
        OP_MUL:  res = prod[WORD_W-1:0];
        OP_MAC:  res = prod[WORD_W-1:0] + opp;
        OP_MSUB: res = opp - prod[WORD_W-1:0];
        OP_ADD:  res = opd + opp;
        default: res = opp;
      endcase
      lanes.d = opd;
      lanes.p = res;
      lanes.b = opb;
    end
    return {lanes.p, lanes.b};
  endfunction

  // en and data_in were captured before the edge that just went by
  always @(negedge clk)
  begin
    if (pending_en)
    begin
      hist.push_back(pending_in);
      if (hist.size() >= DEPTH)
      begin
        exp_out = expected_out(hist.pop_front());
        checks++;
        if (data_out !== exp_out)
        begin
          errors++;
          $display("FAILED t=%0t data_out got %h expected %h", $time, data_out, exp_out);
        end
      end
    end
    else if (pending_hold && data_out !== last_out)
    begin
      errors++;
      $display("FAILED t=%0t data_out got %h expected %h (en low)", $time, data_out, last_out);
    end
    last_out     = data_out;
    pending_en   = en && !rst;
    pending_hold = !en && !rst;
    pending_in   = data_in;
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("run stopped after %0d cycles, stimulus did not finish", cycles);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks

  task automatic write_cfg(input int idx, input cfg_field_e fsel, input logic [WORD_W-1:0] data);
    int n;
    @(posedge clk);
    cfg_wr  <= '{pe_idx: idx[PE_IDX_W-1:0], field: fsel, data: data};
    cfg_req <= 1'b1;
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
      @(negedge clk);
    end
    while (!cfg_ack && n < 8);
    if (!cfg_ack)
    begin
      errors++;
      $display("cfg_ack never rose for a write to element %0d", idx);
    end
    else if (n != 1)
    begin
      errors++;
      $display("FAILED t=%0t cfg_ack rise delay got %0d expected 1", $time, n);
    end
    @(posedge clk);
    cfg_req <= 1'b0;
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
      @(negedge clk);
    end
    while (cfg_ack && n < 8);
    if (cfg_ack)
    begin
      errors++;
      $display("cfg_ack stayed high after cfg_req dropped");
    end
    else if (n != 1)
    begin
      errors++;
      $display("FAILED t=%0t cfg_ack fall delay got %0d expected 1", $time, n);
    end
    if (idx < NUM_PE)
      case (fsel)
        FIELD_CTRL:
        begin
          shadow[idx].op    = pe_op_e'(data[2:0]);
          shadow[idx].src_d = route_src_e'(data[4:3]);
          shadow[idx].src_p = route_src_e'(data[6:5]);
          shadow[idx].src_b = route_src_e'(data[8:7]);
        end
        FIELD_D_IM: shadow[idx].d_im = data;
        FIELD_P_IM: shadow[idx].p_im = data;
        default:    shadow[idx].b_im = data;
      endcase
  endtask

  task automatic configure_pe(input int idx, input pe_op_e op, input route_src_e sd,
                              input route_src_e sp, input route_src_e sb,
                              input logic [WORD_W-1:0] dim, input logic [WORD_W-1:0] pim,
                              input logic [WORD_W-1:0] bim);
    write_cfg(idx, FIELD_CTRL, {7'd0, sb, sp, sd, op});
    write_cfg(idx, FIELD_D_IM, dim);
    write_cfg(idx, FIELD_P_IM, pim);
    write_cfg(idx, FIELD_B_IM, bim);
  endtask

  task automatic random_config();
    logic [2:0] op_r;
    for (int e = 0; e < NUM_PE; e++)
    begin
      op_r = 3'($unsigned($random(seed)) % 5);
      configure_pe(e, pe_op_e'(op_r), route_src_e'(2'($random(seed))),
                   route_src_e'(2'($random(seed))), route_src_e'(2'($random(seed))),
                   16'($random(seed)), 16'($random(seed)), 16'($random(seed)));
    end
  endtask

  task automatic run_stream(input int n, input bit stall);
    for (int i = 0; i < n; i++)
    begin
      @(posedge clk);
      data_in <= $random(seed);
      if (stall)
        en <= (($random(seed) & 3) != 0);  // low about one cycle in four
      else
        en <= 1'b1;
    end
  endtask

  // let the last en edge be compared and then forget what is still in flight
  task automatic stop_stream();
    @(posedge clk);
    en <= 1'b0;
    repeat (2) @(posedge clk);
    hist.delete();
  endtask

  initial
  begin
    rst     = 1'b1;
    en      = 1'b0;
    data_in = '0;
    cfg_req = 1'b0;
    cfg_wr  = '0;
    for (int e = 0; e < NUM_PE; e++)
      shadow[e] = PE_CFG_DEFAULT;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (data_out !== '0)
    begin
      errors++;
      $display("FAILED t=%0t data_out got %h expected 0", $time, data_out);
    end
    if (cfg_ack !== 1'b0)
    begin
      errors++;
      $display("FAILED t=%0t cfg_ack got %b expected 0", $time, cfg_ack);
    end

    run_stream(60, 1'b0);  // default pass-through
    stop_stream();

    configure_pe(0, OP_MUL, SRC_UP_P, SRC_UP_P, SRC_UP_B, 16'h0000, 16'h0000, 16'h0000);
    configure_pe(1, OP_ADD, SRC_IMM, SRC_UP_P, SRC_UP_D, 16'h1234, 16'h0000, 16'h0000);
    configure_pe(2, OP_MAC, SRC_UP_D, SRC_UP_P, SRC_UP_B, 16'h0000, 16'h0000, 16'h0000);
    run_stream(60, 1'b0);
    stop_stream();

    configure_pe(0, OP_MSUB, SRC_IMM, SRC_UP_B, SRC_UP_P, 16'h0007, 16'h0000, 16'h0000);
    configure_pe(1, OP_MAC, SRC_UP_B, SRC_UP_P, SRC_IMM, 16'h0000, 16'h0000, 16'hbeef);
    configure_pe(2, OP_PASS, SRC_UP_D, SRC_UP_P, SRC_IMM, 16'h0000, 16'h0000, 16'h00ff);
    run_stream(60, 1'b0);
    stop_stream();

    for (int k = 0; k < 4; k++)
    begin
      random_config();
      run_stream(50, 1'b0);
      stop_stream();
    end

    run_stream(200, 1'b1);  // stalls on the last configuration
    stop_stream();

    // element 9 is past the chain and nothing may change
    write_cfg(9, FIELD_CTRL, 16'($random(seed)));
    write_cfg(9, FIELD_P_IM, 16'($random(seed)));
    run_stream(40, 1'b0);
    stop_stream();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && checks > 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== virtual_fabric.sv ====
`timescale 1ns/1ps

module virtual_fabric
  import fabric_pkg::*;
#(
  parameter int NUM_PE = 3
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  en,
  input  logic [2*WORD_W-1:0]   data_in,   // {p, b}
  output logic [2*WORD_W-1:0]   data_out,  // {p, b}
  input  logic                  cfg_req,
  input  cfg_write_t            cfg_wr,
  output logic                  cfg_ack
);

  pe_cfg_t [NUM_PE-1:0] cfg_array;
  lane_bundle_t         chain [NUM_PE+1];  // chain[i] feeds element i

  config_port #(
    .NUM_PE (NUM_PE)
  ) u_cfg (
    .clk       (clk),
    .rst       (rst),
    .cfg_req   (cfg_req),
    .cfg_wr    (cfg_wr),
    .cfg_ack   (cfg_ack),
    .cfg_array (cfg_array)
  );

  // stream input has no d lane
  assign chain[0] = '{d: '0, p: data_in[2*WORD_W-1:WORD_W], b: data_in[WORD_W-1:0]};

  ////////////////////////////////////////////////////////////////////////////
  // linear chain of elements

  for (genvar i = 0; i < NUM_PE; i++)
  begin : g_pe
    pe u_pe (
      .clk (clk),
      .rst (rst),
      .en  (en),
      .cfg (cfg_array[i]),
      .up  (chain[i]),
      .out (chain[i+1])
    );
  end

  assign data_out = {chain[NUM_PE].p, chain[NUM_PE].b};

endmodule
